// ==== design/tank_settings.svh ====
//------------------------------
// tank arena settings
// field, box sizes, object counts,
// start positions and shot cadence
//------------------------------
`ifndef TANK_SETTINGS_SVH
`define TANK_SETTINGS_SVH

// visible field in pixels
`define FIELD_W      640
`define FIELD_H      480

// object boxes
`define TANK_SIZE    32
`define WALL_SIZE    32
`define BULLET_R     4    // bullet margin around a wall

// counts
`define TANK_NUM     2
`define WALL_NUM     16
`define POOL_SIZE    8    // bullet slots per tank

// frames between shots, power of two
`define FIRE_PERIOD  16

// start corners
`define TANK0_X0     200
`define TANK0_Y0     200
`define TANK1_X0     400
`define TANK1_Y0     400

`endif

// ==== design/tank_pkg.sv ====
//------------------------------
// tank arena package
// shared types and box overlap tests
//------------------------------
`default_nettype none
`include "tank_settings.svh"

package tank_pkg;

	typedef logic [9:0] coord_t;   // screen coordinate
	typedef logic [6:0] angle_t;   // fine turret angle, top 3 bits = heading

	typedef enum logic [2:0] {
		UP         = 3'd0,
		UP_LEFT    = 3'd1,
		LEFT       = 3'd2,
		DOWN_LEFT  = 3'd3,
		DOWN       = 3'd4,
		DOWN_RIGHT = 3'd5,
		RIGHT      = 3'd6,
		UP_RIGHT   = 3'd7
	} heading_e;

	typedef enum logic [7:0] {
		MK_NONE  = 8'd0,
		MK_LEFT  = 8'd1,
		MK_DOWN  = 8'd2,
		MK_UP    = 8'd3,
		MK_RIGHT = 8'd4
	} move_key_e;

	typedef enum logic [7:0] {
		TK_NONE = 8'd0,
		TK_CCW  = 8'd1,
		TK_CW   = 8'd2,
		TK_FIRE = 8'd3
	} turret_key_e;

	// tank box at corner (x,y) against wall box at (wx,wy)
	function automatic logic tank_wall_overlap(coord_t x, coord_t y, coord_t wx, coord_t wy);
		return (int'(x) < int'(wx) + `WALL_SIZE) && (int'(x) + `TANK_SIZE > int'(wx)) &&
			(int'(y) < int'(wy) + `WALL_SIZE) && (int'(y) + `TANK_SIZE > int'(wy));
	endfunction

	// bullet point near a wall, margin edges count as a touch
	function automatic logic bullet_wall_overlap(coord_t x, coord_t y, coord_t wx, coord_t wy);
		return (int'(x) + `BULLET_R >= int'(wx)) &&
			(int'(x) <= int'(wx) + `WALL_SIZE + `BULLET_R) &&
			(int'(y) + `BULLET_R >= int'(wy)) &&
			(int'(y) <= int'(wy) + `WALL_SIZE + `BULLET_R);
	endfunction

endpackage

`default_nettype wire

// ==== design/tank_mover.sv ====
//------------------------------
// tank mover
// decodes the base key into a one pixel
// step, refuses it at walls and the
// field border, holds position and heading
//------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "tank_settings.svh"

module tank_mover
	import tank_pkg::*;
#(
	parameter coord_t START_X = coord_t'(`TANK0_X0),
	parameter coord_t START_Y = coord_t'(`TANK0_Y0)
) (
	input  logic      Reset,                 // frame clock
	input  logic      frame_clk,             // async reset, active high
	input  move_key_e base_key,
	input  coord_t    wall_x [`WALL_NUM],
	input  coord_t    wall_y [`WALL_NUM],
	output coord_t    tank_x,
	output coord_t    tank_y,
	output heading_e  base_heading
);

	coord_t   cand_x;
	coord_t   cand_y;
	heading_e cand_heading;
	logic     wall_block;
	logic     edge_block;

	//------------------------------
	// candidate step
	//------------------------------
	always_comb begin
		cand_x = tank_x;
		cand_y = tank_y;
		cand_heading = base_heading;
		case (base_key)
			MK_LEFT: begin
				cand_x = tank_x - coord_t'(1);
				cand_heading = LEFT;
			end
			MK_DOWN: begin
				cand_y = tank_y + coord_t'(1);
				cand_heading = DOWN;
			end
			MK_UP: begin
				cand_y = tank_y - coord_t'(1);
				cand_heading = UP;
			end
			MK_RIGHT: begin
				cand_x = tank_x + coord_t'(1);
				cand_heading = RIGHT;
			end
			default: ;   // no key, stand still
		endcase
	end

	//------------------------------
	// blocking
	//------------------------------
	always_comb begin
		wall_block = 1'b0;
		for (int w = 0; w < `WALL_NUM; w++) begin
			if (tank_wall_overlap(cand_x, cand_y, wall_x[w], wall_y[w]))
				wall_block = 1'b1;
		end
	end

	// stepping past 0 wraps high, so one upper bound covers both sides
	assign edge_block = (int'(cand_x) > `FIELD_W - `TANK_SIZE) ||
		(int'(cand_y) > `FIELD_H - `TANK_SIZE);

	always_ff @(posedge Reset or posedge frame_clk) begin
		if (frame_clk) begin
			tank_x       <= START_X;
			tank_y       <= START_Y;
			base_heading <= UP;
		end else begin
			base_heading <= cand_heading;   // turns even when blocked
			if (!wall_block && !edge_block) begin
				tank_x <= cand_x;
				tank_y <= cand_y;
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/turret_ctrl.sv ====
//------------------------------
// turret control
// fine angle, fire latch, shot cadence
// and spawn point of a released shot
//------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "tank_settings.svh"

module turret_ctrl
	import tank_pkg::*;
(
	input  logic        Reset,             // frame clock
	input  logic        frame_clk,         // async reset, active high
	input  turret_key_e turret_key,
	input  coord_t      tank_x,
	input  coord_t      tank_y,
	output heading_e    turret_heading,
	output logic        spawn,
	output coord_t      spawn_x,
	output coord_t      spawn_y,
	output heading_e    spawn_heading
);

	localparam int CNT_W = $clog2(`FIRE_PERIOD);

	angle_t           turret_angle;
	logic             fire_latch;
	logic [CNT_W-1:0] cadence_cnt;   // free running

	assign turret_heading = heading_e'(turret_angle[6:4]);
	assign spawn          = fire_latch && (cadence_cnt == '0);
	assign spawn_heading  = turret_heading;

	always_ff @(posedge Reset or posedge frame_clk) begin
		if (frame_clk) begin
			turret_angle <= '0;
			fire_latch   <= 1'b0;
			cadence_cnt  <= '0;
		end else begin
			cadence_cnt <= cadence_cnt + CNT_W'(1);
			case (turret_key)
				TK_CCW:  turret_angle <= turret_angle + angle_t'(1);
				TK_CW:   turret_angle <= turret_angle - angle_t'(1);
				default: ;
			endcase
			// latch drops one frame after the release slot
			if (cadence_cnt == CNT_W'(1))
				fire_latch <= 1'b0;
			else if (turret_key == TK_FIRE)
				fire_latch <= 1'b1;
		end
	end

	// just outside the tank box along the heading
	always_comb begin
		case (turret_heading)
			UP, DOWN:                    spawn_x = tank_x + coord_t'(`TANK_SIZE / 2);
			DOWN_RIGHT, RIGHT, UP_RIGHT: spawn_x = tank_x + coord_t'(`TANK_SIZE);
			default:                     spawn_x = tank_x - coord_t'(1);
		endcase
		case (turret_heading)
			LEFT, RIGHT:                 spawn_y = tank_y + coord_t'(`TANK_SIZE / 2);
			DOWN_LEFT, DOWN, DOWN_RIGHT: spawn_y = tank_y + coord_t'(`TANK_SIZE);
			default:                     spawn_y = tank_y - coord_t'(1);
		endcase
	end

endmodule

`default_nettype wire

// ==== design/bullet_pool.sv ====
//------------------------------
// bullet pool
// bullet slots of one tank: spawn into
// the lowest free slot, fly one pixel a
// frame, despawn on wall, border or tank
//------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "tank_settings.svh"

module bullet_pool
	import tank_pkg::*;
(
	input  logic     Reset,                     // frame clock
	input  logic     frame_clk,                 // async reset, active high
	input  logic     spawn,
	input  coord_t   spawn_x,
	input  coord_t   spawn_y,
	input  heading_e spawn_heading,
	input  coord_t   tank_x [`TANK_NUM],
	input  coord_t   tank_y [`TANK_NUM],
	input  coord_t   wall_x [`WALL_NUM],
	input  coord_t   wall_y [`WALL_NUM],
	output logic     bullet_alive [`POOL_SIZE],
	output coord_t   bullet_x [`POOL_SIZE],
	output coord_t   bullet_y [`POOL_SIZE],
	output logic     hit [`TANK_NUM]
);

	localparam int IDX_W = $clog2(`POOL_SIZE);

	heading_e         slot_heading [`POOL_SIZE];
	coord_t           step_x [`POOL_SIZE];
	coord_t           step_y [`POOL_SIZE];
	logic             slot_kill [`POOL_SIZE];
	logic             slot_load [`POOL_SIZE];
	logic             tank_hit [`TANK_NUM];
	logic             free_found;
	logic [IDX_W-1:0] free_idx;

	// lowest free slot, scanned from the top down
	always_comb begin
		free_found = 1'b0;
		free_idx   = '0;
		for (int i = `POOL_SIZE - 1; i >= 0; i--) begin
			if (!bullet_alive[i]) begin
				free_found = 1'b1;
				free_idx   = IDX_W'(i);
			end
		end
	end

	//------------------------------
	// flight step
	//------------------------------
	always_comb begin
		for (int i = 0; i < `POOL_SIZE; i++) begin
			step_x[i] = bullet_x[i];
			step_y[i] = bullet_y[i];
			case (slot_heading[i])
				UP_LEFT, LEFT, DOWN_LEFT:    step_x[i] = bullet_x[i] - coord_t'(1);
				DOWN_RIGHT, RIGHT, UP_RIGHT: step_x[i] = bullet_x[i] + coord_t'(1);
				default: ;
			endcase
			case (slot_heading[i])
				UP_RIGHT, UP, UP_LEFT:       step_y[i] = bullet_y[i] - coord_t'(1);
				DOWN_LEFT, DOWN, DOWN_RIGHT: step_y[i] = bullet_y[i] + coord_t'(1);
				default: ;
			endcase
		end
	end

	//------------------------------
	// despawn and hit, judged on the step
	//------------------------------
	always_comb begin
		for (int k = 0; k < `TANK_NUM; k++)
			tank_hit[k] = 1'b0;
		for (int i = 0; i < `POOL_SIZE; i++) begin
			// leaving past 0 wraps high
			slot_kill[i] = (int'(step_x[i]) >= `FIELD_W) || (int'(step_y[i]) >= `FIELD_H);
			for (int w = 0; w < `WALL_NUM; w++) begin
				if (bullet_wall_overlap(step_x[i], step_y[i], wall_x[w], wall_y[w]))
					slot_kill[i] = 1'b1;
			end
			for (int k = 0; k < `TANK_NUM; k++) begin
				if (step_x[i] >= tank_x[k] && int'(step_x[i]) < int'(tank_x[k]) + `TANK_SIZE &&
					step_y[i] >= tank_y[k] && int'(step_y[i]) < int'(tank_y[k]) + `TANK_SIZE) begin
					slot_kill[i] = 1'b1;
					if (bullet_alive[i])
						tank_hit[k] = 1'b1;
				end
			end
			slot_load[i] = spawn && free_found && (free_idx == IDX_W'(i));
		end
	end

	always_ff @(posedge Reset or posedge frame_clk) begin
		if (frame_clk) begin
			for (int i = 0; i < `POOL_SIZE; i++)
				bullet_alive[i] <= 1'b0;
			for (int k = 0; k < `TANK_NUM; k++)
				hit[k] <= 1'b0;
		end else begin
			for (int i = 0; i < `POOL_SIZE; i++)
				bullet_alive[i] <= slot_load[i] || (bullet_alive[i] && !slot_kill[i]);
			for (int k = 0; k < `TANK_NUM; k++)
				hit[k] <= tank_hit[k];   // one frame pulse
		end
	end

	// slot payload
	always_ff @(posedge Reset) begin
		for (int i = 0; i < `POOL_SIZE; i++) begin
			if (slot_load[i]) begin
				bullet_x[i]     <= spawn_x;
				bullet_y[i]     <= spawn_y;
				slot_heading[i] <= spawn_heading;
			end else if (bullet_alive[i]) begin
				bullet_x[i] <= step_x[i];
				bullet_y[i] <= step_y[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== design/tank_arena_top.sv ====
//------------------------------
// tank arena top
// two tanks, each with a mover, a turret
// and a bullet pool; pool hits merged
//------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "tank_settings.svh"

module tank_arena_top
	import tank_pkg::*;
(
	input  logic        Reset,                               // frame clock
	input  logic        frame_clk,                           // async reset, active high
	input  move_key_e   base_key [`TANK_NUM],
	input  turret_key_e turret_key [`TANK_NUM],
	input  coord_t      wall_x [`WALL_NUM],
	input  coord_t      wall_y [`WALL_NUM],
	output coord_t      tank_x [`TANK_NUM],
	output coord_t      tank_y [`TANK_NUM],
	output heading_e    base_heading [`TANK_NUM],
	output heading_e    turret_heading [`TANK_NUM],
	output logic        bullet_alive [`TANK_NUM][`POOL_SIZE],
	output coord_t      bullet_x [`TANK_NUM][`POOL_SIZE],
	output coord_t      bullet_y [`TANK_NUM][`POOL_SIZE],
	output logic        hit [`TANK_NUM]
);

	logic     spawn [`TANK_NUM];
	coord_t   spawn_x [`TANK_NUM];
	coord_t   spawn_y [`TANK_NUM];
	heading_e spawn_heading [`TANK_NUM];
	logic     pool_hit [`TANK_NUM][`TANK_NUM];   // [pool][tank]

	for (genvar t = 0; t < `TANK_NUM; t++) begin : g_tank
		tank_mover #(
			.START_X((t == 0) ? coord_t'(`TANK0_X0) : coord_t'(`TANK1_X0)),
			.START_Y((t == 0) ? coord_t'(`TANK0_Y0) : coord_t'(`TANK1_Y0))
		) u_mover (
			.Reset(Reset), .frame_clk(frame_clk),
			.base_key(base_key[t]),
			.wall_x(wall_x), .wall_y(wall_y),
			.tank_x(tank_x[t]), .tank_y(tank_y[t]),
			.base_heading(base_heading[t])
		);

		turret_ctrl u_turret (
			.Reset(Reset), .frame_clk(frame_clk),
			.turret_key(turret_key[t]),
			.tank_x(tank_x[t]), .tank_y(tank_y[t]),
			.turret_heading(turret_heading[t]),
			.spawn(spawn[t]), .spawn_x(spawn_x[t]), .spawn_y(spawn_y[t]),
			.spawn_heading(spawn_heading[t])
		);

		// every pool sees both tanks
		bullet_pool u_pool (
			.Reset(Reset), .frame_clk(frame_clk),
			.spawn(spawn[t]), .spawn_x(spawn_x[t]), .spawn_y(spawn_y[t]),
			.spawn_heading(spawn_heading[t]),
			.tank_x(tank_x), .tank_y(tank_y),
			.wall_x(wall_x), .wall_y(wall_y),
			.bullet_alive(bullet_alive[t]),
			.bullet_x(bullet_x[t]), .bullet_y(bullet_y[t]),
			.hit(pool_hit[t])
		);
	end

	// a tank is hit by a bullet from any pool
	always_comb begin
		for (int k = 0; k < `TANK_NUM; k++) begin
			hit[k] = 1'b0;
			for (int p = 0; p < `TANK_NUM; p++)
				hit[k] = hit[k] | pool_hit[p][k];
		end
	end

endmodule

`default_nettype wire

// ==== dv/tank_arena_tb.sv ====
//------------------------------
// tank arena testbench
// directed tests of movement, blocking,
// turret rotation, shots and tank hits
//------------------------------
`timescale 1ns/100ps
`default_nettype none
`include "tank_settings.svh"

module tank_arena_tb
	import tank_pkg::*;
();

	localparam int CYCLE_LIMIT = 2500;
	localparam int WALL0_X     = 140;   // blocks tank 0 on its way left
	localparam int WALL0_Y     = 200;
	localparam int TARGET_Y    = 100;   // wall hit by the upward shot

	logic        Reset;                 // frame clock
	logic        frame_clk;             // async reset, active high
	move_key_e   base_key [`TANK_NUM];
	turret_key_e turret_key [`TANK_NUM];
	coord_t      wall_x [`WALL_NUM];
	coord_t      wall_y [`WALL_NUM];
	coord_t      tank_x [`TANK_NUM];
	coord_t      tank_y [`TANK_NUM];
	heading_e    base_heading [`TANK_NUM];
	heading_e    turret_heading [`TANK_NUM];
	logic        bullet_alive [`TANK_NUM][`POOL_SIZE];
	coord_t      bullet_x [`TANK_NUM][`POOL_SIZE];
	coord_t      bullet_y [`TANK_NUM][`POOL_SIZE];
	logic        hit [`TANK_NUM];

	int          error_count = 0;
	int          cycle_count = 0;
	int unsigned lcg_state   = 32'd7396;

	tank_arena_top DUT (
		.Reset(Reset), .frame_clk(frame_clk),
		.base_key(base_key), .turret_key(turret_key),
		.wall_x(wall_x), .wall_y(wall_y),
		.tank_x(tank_x), .tank_y(tank_y),
		.base_heading(base_heading), .turret_heading(turret_heading),
		.bullet_alive(bullet_alive), .bullet_x(bullet_x), .bullet_y(bullet_y),
		.hit(hit)
	);

	always #50 Reset = ~Reset;

	always @(posedge Reset) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Error: run stopped after %0d cycles without finishing", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	function automatic int unsigned lcg_next(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	//------------------------------
	// compare tasks
	//------------------------------
	task automatic check_coord(input string what, input coord_t got, input coord_t exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			error_count++;
		end
	endtask

	task automatic check_heading(input string what, input heading_e got, input heading_e exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %s (%0d), expected %s (%0d)",
				$time, what, got.name(), got, exp.name(), exp);
			error_count++;
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
			error_count++;
		end
	endtask

	//------------------------------
	// stimulus helpers
	//------------------------------
	// wall 0 by hand, the rest in the upper right, clear of every path
	task automatic place_walls();
		wall_x[0] = coord_t'(WALL0_X);
		wall_y[0] = coord_t'(WALL0_Y);
		for (int w = 1; w < `WALL_NUM; w++) begin
			lcg_state = lcg_next(lcg_state);
			wall_x[w] = coord_t'(480 + (lcg_state >> 16) % 96);
			lcg_state = lcg_next(lcg_state);
			wall_y[w] = coord_t'((lcg_state >> 16) % 160);
		end
	endtask

	// key held for exactly that many edges, then released
	task automatic hold_move(input int t, input move_key_e key, input int cycles);
		repeat (cycles) begin
			@(posedge Reset);
			base_key[t] <= key;
		end
		@(posedge Reset);
		base_key[t] <= MK_NONE;
		@(negedge Reset);
	endtask

	task automatic hold_turret(input int t, input turret_key_e key, input int cycles);
		repeat (cycles) begin
			@(posedge Reset);
			turret_key[t] <= key;
		end
		@(posedge Reset);
		turret_key[t] <= TK_NONE;
		@(negedge Reset);
	endtask

	// fire until slot 0 comes alive, returns just after the next edge
	task automatic fire_shot(input int t, output coord_t sx, output coord_t sy);
		logic seen;
		int   n;
		seen = 1'b0;
		n = 0;
		while (!seen && n < `FIRE_PERIOD + 2) begin
			@(posedge Reset);
			turret_key[t] <= TK_FIRE;
			@(negedge Reset);
			seen = bullet_alive[t][0];
			n++;
		end
		sx = bullet_x[t][0];
		sy = bullet_y[t][0];
		@(posedge Reset);
		turret_key[t] <= TK_NONE;
		if (!seen) begin
			$display("Error: no bullet appeared in slot 0 of tank %0d after the fire key", t);
			error_count++;
		end
	endtask

	//------------------------------
	// directed tests
	//------------------------------
	task automatic check_after_reset();
		check_coord("tank_x[0]", tank_x[0], coord_t'(`TANK0_X0));
		check_coord("tank_y[0]", tank_y[0], coord_t'(`TANK0_Y0));
		check_coord("tank_x[1]", tank_x[1], coord_t'(`TANK1_X0));
		check_coord("tank_y[1]", tank_y[1], coord_t'(`TANK1_Y0));
		for (int t = 0; t < `TANK_NUM; t++) begin
			check_heading("base_heading", base_heading[t], UP);
			check_heading("turret_heading", turret_heading[t], UP);
			check_bit("hit", hit[t], 1'b0);
			for (int s = 0; s < `POOL_SIZE; s++)
				check_bit("bullet_alive", bullet_alive[t][s], 1'b0);
		end
	endtask

	task automatic move_and_return();
		hold_move(0, MK_LEFT, 10);
		check_coord("tank_x[0]", tank_x[0], coord_t'(`TANK0_X0 - 10));
		check_coord("tank_y[0]", tank_y[0], coord_t'(`TANK0_Y0));
		check_heading("base_heading[0]", base_heading[0], LEFT);
		hold_move(0, MK_RIGHT, 10);
		check_coord("tank_x[0]", tank_x[0], coord_t'(`TANK0_X0));
		check_heading("base_heading[0]", base_heading[0], RIGHT);
	endtask

	task automatic wall_and_edge_block();
		hold_move(0, MK_LEFT, 40);
		check_coord("tank_x[0]", tank_x[0], coord_t'(WALL0_X + `WALL_SIZE));
		check_heading("base_heading[0]", base_heading[0], LEFT);
		hold_move(0, MK_UP, `TANK0_Y0 + 10);   // runs into the top border
		check_coord("tank_y[0]", tank_y[0], coord_t'(0));
		check_coord("tank_x[0]", tank_x[0], coord_t'(WALL0_X + `WALL_SIZE));
		check_heading("base_heading[0]", base_heading[0], UP);
		// back to the start corner
		hold_move(0, MK_DOWN, `TANK0_Y0);
		hold_move(0, MK_RIGHT, `TANK0_X0 - (WALL0_X + `WALL_SIZE));
		check_coord("tank_x[0]", tank_x[0], coord_t'(`TANK0_X0));
		check_coord("tank_y[0]", tank_y[0], coord_t'(`TANK0_Y0));
	endtask

	task automatic turret_rotation();
		hold_turret(0, TK_CCW, 16);
		check_heading("turret_heading[0]", turret_heading[0], UP_LEFT);
		hold_turret(0, TK_CW, 16);
		check_heading("turret_heading[0]", turret_heading[0], UP);
	endtask

	task automatic shot_into_wall();
		coord_t sx, sy, exp_x, exp_y, last_y;
		int     n;
		@(posedge Reset);
		wall_x[1] <= coord_t'(`TANK0_X0);   // straight above tank 0
		wall_y[1] <= coord_t'(TARGET_Y);
		fire_shot(0, sx, sy);
		exp_x = coord_t'(`TANK0_X0 + 16);   // middle of the top edge
		exp_y = coord_t'(`TANK0_Y0 - 1);
		check_coord("spawn x", sx, exp_x);
		check_coord("spawn y", sy, exp_y);
		last_y = exp_y;
		exp_y = exp_y - coord_t'(1);
		n = 0;
		@(negedge Reset);
		while (bullet_alive[0][0] && n < 100) begin
			check_coord("bullet_x[0][0]", bullet_x[0][0], exp_x);
			check_coord("bullet_y[0][0]", bullet_y[0][0], exp_y);
			last_y = bullet_y[0][0];
			exp_y = exp_y - coord_t'(1);
			n++;
			@(negedge Reset);
		end
		if (n >= 100) begin
			$display("Error: upward bullet of tank 0 was never cleared by the wall");
			error_count++;
		end
		// last point before the margin of the wall
		check_coord("last bullet_y", last_y, coord_t'(TARGET_Y + `WALL_SIZE + `BULLET_R + 1));
	endtask

	task automatic shot_hits_tank();
		coord_t sx, sy, exp_p, last_x, last_y;
		int     n;
		hold_turret(0, TK_CCW, 80);
		check_heading("turret_heading[0]", turret_heading[0], DOWN_RIGHT);
		fire_shot(0, sx, sy);
		check_coord("spawn x", sx, coord_t'(`TANK0_X0 + 32));   // just past the lower right corner
		check_coord("spawn y", sy, coord_t'(`TANK0_Y0 + 32));
		exp_p = coord_t'(`TANK0_X0 + 33);   // start corner is on the diagonal
		last_x = sx;
		last_y = sy;
		n = 0;
		@(negedge Reset);
		while (bullet_alive[0][0] && n < 200) begin
			check_coord("bullet_x[0][0]", bullet_x[0][0], exp_p);
			check_coord("bullet_y[0][0]", bullet_y[0][0], exp_p);
			last_x = bullet_x[0][0];
			last_y = bullet_y[0][0];
			exp_p = exp_p + coord_t'(1);
			n++;
			@(negedge Reset);
		end
		if (n >= 200) begin
			$display("Error: diagonal bullet of tank 0 never reached tank 1");
			error_count++;
		end
		check_coord("last bullet_x", last_x, coord_t'(`TANK1_X0 - 1));
		check_coord("last bullet_y", last_y, coord_t'(`TANK1_Y0 - 1));
		check_bit("hit[1]", hit[1], 1'b1);
		check_bit("hit[0]", hit[0], 1'b0);
		@(negedge Reset);
		check_bit("hit[1]", hit[1], 1'b0);   // single frame pulse
		check_bit("bullet_alive[0][0]", bullet_alive[0][0], 1'b0);
	endtask

	initial begin
		Reset = 1'b0;
		frame_clk = 1'b1;
		for (int t = 0; t < `TANK_NUM; t++) begin
			base_key[t] = MK_NONE;
			turret_key[t] = TK_NONE;
		end
		place_walls();
		repeat (5) @(posedge Reset);
		frame_clk <= 1'b0;
		@(negedge Reset);

		check_after_reset();
		move_and_return();
		wall_and_edge_block();
		turret_rotation();
		shot_into_wall();
		shot_hits_tank();

		$display("errors: %0d", error_count);
		if (error_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+design
design/tank_pkg.sv
design/tank_mover.sv
design/turret_ctrl.sv
design/bullet_pool.sv
design/tank_arena_top.sv
dv/tank_arena_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the tank arena testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps -f compile.f \
	--top-module tank_arena_tb -o tank_arena_sim \
	&& ./obj_dir/tank_arena_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && exit 1 || exit 0
